// ==== uart_pkg.sv ====
// Fixed 8-bit framing with a short bit period for simulation; register offsets assume 32-bit access
`default_nettype none

package uart_pkg;

  ////////////////////
  // Serial bit timing
  localparam int CLKS_PER_BIT = 16;
  localparam int HALF_BIT     = CLKS_PER_BIT / 2;
  localparam int DATA_BITS    = 8;
  localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);
  localparam int BIT_CNT_W    = $clog2(DATA_BITS + 1);

  // Receive FIFO sizing
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  ////////////////////
  // AXI4-Lite bus and register map
  localparam int AXI_ADDR_W = 4;
  localparam int AXI_DATA_W = 32;
  localparam logic [AXI_ADDR_W-1:0] ADDR_CTRL   = AXI_ADDR_W'(0);
  localparam logic [AXI_ADDR_W-1:0] ADDR_STATUS = AXI_ADDR_W'(4);
  localparam logic [AXI_ADDR_W-1:0] ADDR_DATA   = AXI_ADDR_W'(8);

  // One received character, data in the upper bits
  typedef struct packed {
    logic [DATA_BITS-1:0] data;
    logic                 parity_err;
    logic                 frame_err;
  } rx_char_t;

  // CTRL layout, rx_en is bit 2
  typedef struct packed {
    logic rx_en;
    logic parity_en;
    logic parity_odd;
  } uart_ctrl_t;

  // STATUS layout, overrun sits in bit 2 so a W1C on bit 2 clears it
  typedef struct packed {
    logic overrun;
    logic full;
    logic not_empty;
  } uart_status_t;

  typedef enum logic [2:0] {IDLE, START, DATA, PARITY, STOP} rx_state_t;

endpackage

`default_nettype wire

// ==== axil_if.sv ====
// AXI4-Lite without wstrb or prot; every access is a full 32-bit word and responses are OKAY
`timescale 1ns/1ps
`default_nettype none

interface axil_if;
  import uart_pkg::*;

  // Write address and data
  logic                  awvalid;
  logic                  awready;
  logic [AXI_ADDR_W-1:0] awaddr;
  logic                  wvalid;
  logic                  wready;
  logic [AXI_DATA_W-1:0] wdata;

  // Write response
  logic                  bvalid;
  logic                  bready;
  logic [1:0]            bresp;

  // Read address and data
  logic                  arvalid;
  logic                  arready;
  logic [AXI_ADDR_W-1:0] araddr;
  logic                  rvalid;
  logic                  rready;
  logic [AXI_DATA_W-1:0] rdata;
  logic [1:0]            rresp;

  modport master (
    output awvalid, awaddr, wvalid, wdata, bready, arvalid, araddr, rready,
    input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
  );

  modport slave (
    input  awvalid, awaddr, wvalid, wdata, bready, arvalid, araddr, rready,
    output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
  );

endinterface

`default_nettype wire

// ==== uart_baud_timer.sv ====
// Bit period is the package constant CLKS_PER_BIT; load_half takes priority over load_full
`timescale 1ns/1ps
`default_nettype none

module uart_baud_timer (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  load_half,
  input  wire  load_full,
  input  wire  bit_clr,
  output logic bit_tick,
  output logic bits_done
);
  import uart_pkg::*;

  logic [BAUD_CNT_W-1:0] clk_cnt;
  logic [BIT_CNT_W-1:0]  bit_cnt;

  // Mid-bit strobe when the period counter runs out
  assign bit_tick  = (clk_cnt == '0);
  assign bits_done = (bit_cnt == '0);

  // Half period lands the first sample in the middle of the start bit
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      clk_cnt <= BAUD_CNT_W'(CLKS_PER_BIT - 1);
    end else if (load_half) begin
      clk_cnt <= BAUD_CNT_W'(HALF_BIT - 1);
    end else if (load_full || bit_tick) begin
      clk_cnt <= BAUD_CNT_W'(CLKS_PER_BIT - 1);
    end else begin
      clk_cnt <= clk_cnt - 1'b1;
    end
  end

  // Data bit counter, stops at zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bit_cnt <= '0;
    end else if (bit_clr) begin
      bit_cnt <= BIT_CNT_W'(DATA_BITS);
    end else if (bit_tick && !bits_done) begin
      bit_cnt <= bit_cnt - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== uart_rx_sampler.sv ====
// rx is asynchronous and idles high; the synchronizer adds 2 cycles before any decision
`timescale 1ns/1ps
`default_nettype none

module uart_rx_sampler (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire                             rx,
  input  wire                             shift_en,
  input  wire                             clr,
  output logic                            rx_sync,
  output logic                            fall,
  output logic [uart_pkg::DATA_BITS-1:0]  shift_data,
  output logic                            parity_acc
);
  import uart_pkg::*;

  logic rx_meta;
  logic rx_dly;

  ////////////////////
  // Two-flop synchronizer plus edge delay
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_dly  <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_dly  <= rx_sync;
    end
  end

  // High for one cycle on a 1 -> 0 transition
  assign fall = rx_dly & ~rx_sync;

  ////////////////////
  // Data shift register, LSB arrives first
  always_ff @(posedge clk) begin
    if (clr) begin
      shift_data <= '0;
      parity_acc <= 1'b0;
    end else if (shift_en) begin
      shift_data <= {rx_sync, shift_data[DATA_BITS-1:1]};
      // Running XOR of the data bits
      parity_acc <= parity_acc ^ rx_sync;
    end
  end

endmodule

`default_nettype wire

// ==== uart_rx_fsm.sv ====
// One stop bit only; a false start (line high at mid start bit) is dropped without a push
`timescale 1ns/1ps
`default_nettype none

module uart_rx_fsm (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire uart_pkg::uart_ctrl_t       ctrl,
  input  wire                             rx_sync,
  input  wire                             fall,
  input  wire                             bit_tick,
  input  wire                             bits_done,
  input  wire [uart_pkg::DATA_BITS-1:0]   shift_data,
  input  wire                             parity_acc,
  output logic                            load_half,
  output logic                            load_full,
  output logic                            bit_clr,
  output logic                            shift_en,
  output logic                            samp_clr,
  output logic                            push,
  output uart_pkg::rx_char_t              push_char
);
  import uart_pkg::*;

  rx_state_t state;
  rx_state_t state_nxt;
  logic      stop_seen;
  logic      parity_err_q;
  logic      frame_err_q;

  ////////////////////
  // Next state and timer / sampler steering
  always_comb begin
    state_nxt = state;
    load_half = 1'b0;
    load_full = 1'b0;
    bit_clr   = 1'b0;
    shift_en  = 1'b0;
    samp_clr  = 1'b0;
    push      = 1'b0;
    case (state)
      IDLE: begin
        // Keep the period counter parked until a start edge
        load_full = 1'b1;
        if (fall && ctrl.rx_en) begin
          load_half = 1'b1;
          samp_clr  = 1'b1;
          state_nxt = START;
        end
      end
      START: begin
        if (bit_tick) begin
          if (rx_sync) begin
            state_nxt = IDLE;
          end else begin
            bit_clr   = 1'b1;
            state_nxt = DATA;
          end
        end
      end
      DATA: begin
        shift_en = bit_tick;
        if (bits_done) begin
          state_nxt = ctrl.parity_en ? PARITY : STOP;
        end
      end
      PARITY: begin
        if (bit_tick) begin
          state_nxt = STOP;
        end
      end
      STOP: begin
        // Push one cycle after the stop sample
        if (stop_seen) begin
          push      = 1'b1;
          state_nxt = IDLE;
        end
      end
      default: state_nxt = IDLE;
    endcase
    // Disabled receiver always falls back to IDLE
    if (!ctrl.rx_en) begin
      state_nxt = IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= IDLE;
      stop_seen <= 1'b0;
    end else begin
      state     <= state_nxt;
      stop_seen <= (state == STOP) && (state_nxt == STOP) && (stop_seen || bit_tick);
    end
  end

  // Error flags of the frame in flight
  always_ff @(posedge clk) begin
    if (state == DATA && bits_done) begin
      parity_err_q <= 1'b0;
    end else if (state == PARITY && bit_tick) begin
      // Even: data ^ parity must be 0, odd flips the expectation
      parity_err_q <= parity_acc ^ rx_sync ^ ctrl.parity_odd;
    end
    if (state == STOP && bit_tick && !stop_seen) begin
      frame_err_q <= ~rx_sync;
    end
  end

  assign push_char = '{data: shift_data, parity_err: parity_err_q, frame_err: frame_err_q};

endmodule

`default_nettype wire

// ==== uart_rx_fifo.sv ====
// Pushes into a full FIFO are lost and only leave the sticky overrun flag behind
`timescale 1ns/1ps
`default_nettype none

module uart_rx_fifo (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 push,
  input  wire uart_pkg::rx_char_t push_char,
  input  wire                 pop,
  input  wire                 overrun_clr,
  output uart_pkg::rx_char_t  rd_char,
  output logic                not_empty,
  output logic                full,
  output logic                overrun
);
  import uart_pkg::*;

  rx_char_t              mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_CNT_W-1:0] count;
  logic                  push_ok;
  logic                  pop_ok;

  // Circular pointer step
  function automatic logic [FIFO_PTR_W-1:0] ptr_inc(input logic [FIFO_PTR_W-1:0] ptr);
    return (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full      = (count == FIFO_CNT_W'(FIFO_DEPTH));
  assign not_empty = (count != '0);
  assign push_ok   = push && !full;
  assign pop_ok    = pop && not_empty;
  // Head of queue shown without a read cycle
  assign rd_char   = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_char;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      overrun <= 1'b0;
    end else begin
      if (push_ok) wr_ptr <= ptr_inc(wr_ptr);
      if (pop_ok) rd_ptr <= ptr_inc(rd_ptr);
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Set wins over a same-cycle clear
      if (push && full) begin
        overrun <= 1'b1;
      end else if (overrun_clr) begin
        overrun <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== uart_axil_regs.sv ====
// Single outstanding read and write; unmapped reads return 0 and unmapped writes are ignored
`timescale 1ns/1ps
`default_nettype none

module uart_axil_regs (
  input  wire                     clk,
  input  wire                     rst_n,
  axil_if.slave                   bus,
  output uart_pkg::uart_ctrl_t    ctrl,
  input  wire uart_pkg::rx_char_t rd_char,
  input  wire                     not_empty,
  input  wire                     full,
  input  wire                     overrun,
  output logic                    pop,
  output logic                    overrun_clr
);
  import uart_pkg::*;

  logic                  wr_acc;
  logic                  rd_acc;
  uart_status_t          status;
  uart_status_t          wr_status;
  logic [AXI_DATA_W-1:0] rd_word;

  ////////////////////
  // Handshake, a pending response blocks its channel
  assign wr_acc      = bus.awvalid && bus.wvalid && !bus.bvalid;
  assign rd_acc      = bus.arvalid && !bus.rvalid;
  assign bus.awready = wr_acc;
  assign bus.wready  = wr_acc;
  assign bus.arready = !bus.rvalid;
  assign bus.bresp   = 2'b00;
  assign bus.rresp   = 2'b00;

  assign status    = '{overrun: overrun, full: full, not_empty: not_empty};
  assign wr_status = uart_status_t'(bus.wdata[$bits(uart_status_t)-1:0]);

  // DATA read pops only when there is something to pop
  assign pop         = rd_acc && (bus.araddr == ADDR_DATA) && not_empty;
  // W1C on the overrun bit
  assign overrun_clr = wr_acc && (bus.awaddr == ADDR_STATUS) && wr_status.overrun;

  // Read mux
  always_comb begin
    rd_word = '0;
    case (bus.araddr)
      ADDR_CTRL:   rd_word[$bits(uart_ctrl_t)-1:0] = ctrl;
      ADDR_STATUS: rd_word[$bits(uart_status_t)-1:0] = status;
      ADDR_DATA: begin
        rd_word[$bits(rx_char_t)-1:0] = rd_char;
        rd_word[AXI_DATA_W-1]         = not_empty;
      end
      default: rd_word = '0;
    endcase
  end

  ////////////////////
  // CTRL register and response valids
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ctrl       <= '0;
      bus.bvalid <= 1'b0;
      bus.rvalid <= 1'b0;
    end else begin
      if (wr_acc && bus.awaddr == ADDR_CTRL) begin
        ctrl <= uart_ctrl_t'(bus.wdata[$bits(uart_ctrl_t)-1:0]);
      end
      if (wr_acc) begin
        bus.bvalid <= 1'b1;
      end else if (bus.bready) begin
        bus.bvalid <= 1'b0;
      end
      if (rd_acc) begin
        bus.rvalid <= 1'b1;
      end else if (bus.rready) begin
        bus.rvalid <= 1'b0;
      end
    end
  end

  // Read data held with rvalid
  always_ff @(posedge clk) begin
    if (rd_acc) begin
      bus.rdata <= rd_word;
    end
  end

endmodule

`default_nettype wire

// ==== uart_rx_top.sv ====
// Reception stays off after reset until software sets CTRL.rx_en
`timescale 1ns/1ps
`default_nettype none

module uart_rx_top (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire                              rx,
  input  wire                              awvalid,
  output logic                             awready,
  input  wire  [uart_pkg::AXI_ADDR_W-1:0]  awaddr,
  input  wire                              wvalid,
  output logic                             wready,
  input  wire  [uart_pkg::AXI_DATA_W-1:0]  wdata,
  output logic                             bvalid,
  input  wire                              bready,
  output logic [1:0]                       bresp,
  input  wire                              arvalid,
  output logic                             arready,
  input  wire  [uart_pkg::AXI_ADDR_W-1:0]  araddr,
  output logic                             rvalid,
  input  wire                              rready,
  output logic [uart_pkg::AXI_DATA_W-1:0]  rdata,
  output logic [1:0]                       rresp
);
  import uart_pkg::*;

  axil_if bus ();

  uart_ctrl_t           ctrl;
  rx_char_t             push_char;
  rx_char_t             rd_char;
  logic                 rx_sync, fall, parity_acc;
  logic [DATA_BITS-1:0] shift_data;
  logic                 bit_tick, bits_done, load_half, load_full, bit_clr;
  logic                 shift_en, samp_clr, push, pop, overrun_clr;
  logic                 not_empty, full, overrun;

  ////////////////////
  // Master side of the bus from the plain ports
  assign bus.awvalid = awvalid;
  assign bus.awaddr  = awaddr;
  assign bus.wvalid  = wvalid;
  assign bus.wdata   = wdata;
  assign bus.bready  = bready;
  assign bus.arvalid = arvalid;
  assign bus.araddr  = araddr;
  assign bus.rready  = rready;
  assign awready     = bus.awready;
  assign wready      = bus.wready;
  assign bvalid      = bus.bvalid;
  assign bresp       = bus.bresp;
  assign arready     = bus.arready;
  assign rvalid      = bus.rvalid;
  assign rdata       = bus.rdata;
  assign rresp       = bus.rresp;

  uart_axil_regs regs_inst (
    .clk, .rst_n, .bus(bus.slave), .ctrl, .rd_char, .not_empty, .full, .overrun,
    .pop, .overrun_clr
  );

  uart_rx_sampler sampler_inst (
    .clk, .rst_n, .rx, .shift_en, .clr(samp_clr), .rx_sync, .fall, .shift_data,
    .parity_acc
  );

  uart_baud_timer timer_inst (
    .clk, .rst_n, .load_half, .load_full, .bit_clr, .bit_tick, .bits_done
  );

  uart_rx_fsm fsm_inst (
    .clk, .rst_n, .ctrl, .rx_sync, .fall, .bit_tick, .bits_done, .shift_data,
    .parity_acc, .load_half, .load_full, .bit_clr, .shift_en, .samp_clr, .push,
    .push_char
  );

  uart_rx_fifo fifo_inst (
    .clk, .rst_n, .push, .push_char, .pop, .overrun_clr, .rd_char, .not_empty,
    .full, .overrun
  );

endmodule

`default_nettype wire

// ==== uart_rx_properties.sv ====
// Bound into uart_rx_top; checks are idle while rst_n is low and state is taken from the FSM
`timescale 1ns/1ps
`default_nettype none

module uart_rx_properties (
  input wire                      clk,
  input wire                      rst_n,
  input wire                      bvalid,
  input wire                      bready,
  input wire                      rvalid,
  input wire                      rready,
  input wire                      bit_tick,
  input wire                      push,
  input wire                      pop,
  input wire uart_pkg::rx_state_t state
);
  import uart_pkg::*;

  // Number of assertion failures so far
  int                    assert_fails = 0;
  // FIFO occupancy rebuilt from push and pop
  logic [FIFO_CNT_W-1:0] occ;
  logic                  push_acc;

  // A push into a full FIFO is dropped
  assign push_acc = push && (occ != FIFO_CNT_W'(FIFO_DEPTH));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      occ <= '0;
    end else begin
      occ <= occ + FIFO_CNT_W'(push_acc) - FIFO_CNT_W'(pop);
    end
  end

  ////////////////////
  // AXI response channels
  property hold_until_ready(logic valid, logic ready);
    @(posedge clk) disable iff (!rst_n)
      valid && !ready |=> valid;
  endproperty

  bvalid_hold: assert property (hold_until_ready(bvalid, bready))
    else begin
      $error("bvalid dropped before bready");
      assert_fails++;
    end

  rvalid_hold: assert property (hold_until_ready(rvalid, rready))
    else begin
      $error("rvalid dropped before rready");
      assert_fails++;
    end

  ////////////////////
  // FIFO push and pop
  push_in_stop: assert property (@(posedge clk) disable iff (!rst_n)
      push |-> $past(state == STOP && bit_tick))
    else begin
      $error("push not one cycle after the stop sample");
      assert_fails++;
    end

  pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> occ != '0)
    else begin
      $error("pop on empty FIFO");
      assert_fails++;
    end

endmodule

bind uart_rx_top uart_rx_properties props_inst (
  .clk, .rst_n, .bvalid, .bready, .rvalid, .rready, .bit_tick, .push, .pop,
  .state(fsm_inst.state)
);

`default_nettype wire

// ==== tb_uart_rx.sv ====
// Self-checking testbench; assumes 100 ns clock, idle-high rx line and one access at a time on AXI
`timescale 1ns/1ps
`default_nettype none

module tb_uart_rx;
  import uart_pkg::*;

  localparam int CLK_PERIOD = 100;
  // 20 plain, 24 parity, 4 framing, 5 overrun, 1 while disabled
  localparam int NUM_FRAMES = 54;
  localparam int TIMEOUT_NS =
    (NUM_FRAMES * 12 * CLKS_PER_BIT + NUM_FRAMES * 60 + 2000) * CLK_PERIOD;

  logic                  clk     = 1'b0;
  logic                  rst_n   = 1'b0;
  logic                  rx      = 1'b1;
  logic                  awvalid = 1'b0;
  logic                  awready;
  logic [AXI_ADDR_W-1:0] awaddr  = '0;
  logic                  wvalid  = 1'b0;
  logic                  wready;
  logic [AXI_DATA_W-1:0] wdata   = '0;
  logic                  bvalid;
  logic                  bready  = 1'b0;
  logic [1:0]            bresp;
  logic                  arvalid = 1'b0;
  logic                  arready;
  logic [AXI_ADDR_W-1:0] araddr  = '0;
  logic                  rvalid;
  logic                  rready  = 1'b0;
  logic [AXI_DATA_W-1:0] rdata;
  logic [1:0]            rresp;

  // Expected FIFO contents, overrun flag and CTRL copy
  rx_char_t    exp_q[$];
  logic        exp_ovr  = 1'b0;
  uart_ctrl_t  cur_ctrl = '0;
  logic [31:0] lfsr     = 32'hebb1;

  uart_rx_top uart_rx_top_inst (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////
  // Fibonacci LFSR with taps x^32+x^22+x^2+x+1
  function automatic logic rand_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [DATA_BITS-1:0] rand_byte();
    logic [DATA_BITS-1:0] b;
    for (int i = 0; i < DATA_BITS; i++) begin
      b[i] = rand_bit();
    end
    return b;
  endfunction

  ////////////////////
  // Compare tasks for each result type
  task automatic check_char(input string name, input rx_char_t got, input rx_char_t exp);
    if (got !== exp) begin
      $display("error: %0t ns: %s = %h, expected %h", $time, name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "character mismatch");
    end
  endtask

  task automatic check_status(input string name, input uart_status_t got,
                              input uart_status_t exp);
    if (got !== exp) begin
      $display("error: %0t ns: %s = %b, expected %b", $time, name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "status mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error: %0t ns: %s = %b, expected %b", $time, name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      $display("error: %0t ns: %s = %b, expected %b", $time, name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "response mismatch");
    end
  endtask

  ////////////////////
  // AXI4-Lite master drives on the rising edge and samples on the falling edge
  task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr,
                           input logic [AXI_DATA_W-1:0] data);
    @(posedge clk);
    awvalid <= 1'b1;
    awaddr  <= addr;
    wvalid  <= 1'b1;
    wdata   <= data;
    @(negedge clk);
    while (!(awready && wready)) @(negedge clk);
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    check_resp("bresp", bresp, 2'b00);
    // One stalled cycle on bready before taking the response
    @(posedge clk);
    bready <= 1'b1;
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr,
                          output logic [AXI_DATA_W-1:0] data);
    @(posedge clk);
    arvalid <= 1'b1;
    araddr  <= addr;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    arvalid <= 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    // One stalled cycle on rready before taking the data
    @(posedge clk);
    rready <= 1'b1;
    @(negedge clk);
    check_resp("rresp", rresp, 2'b00);
    data = rdata;
    @(posedge clk);
    rready <= 1'b0;
  endtask

  task automatic set_ctrl(input uart_ctrl_t c);
    cur_ctrl = c;
    axi_write(ADDR_CTRL, AXI_DATA_W'(c));
  endtask

  task automatic read_status(output uart_status_t st);
    logic [AXI_DATA_W-1:0] word;
    axi_read(ADDR_STATUS, word);
    st = uart_status_t'(word[$bits(uart_status_t)-1:0]);
  endtask

  // Expected STATUS from the queue model
  function automatic uart_status_t model_status();
    uart_status_t st;
    st.overrun   = exp_ovr;
    st.full      = (exp_q.size() == FIFO_DEPTH);
    st.not_empty = (exp_q.size() != 0);
    return st;
  endfunction

  task automatic expect_status();
    uart_status_t st;
    read_status(st);
    check_status("STATUS", st, model_status());
  endtask

  ////////////////////
  // Serial driver holds each bit for one bit period
  task automatic drive_bit(input logic b);
    @(posedge clk);
    rx <= b;
    repeat (CLKS_PER_BIT - 1) @(posedge clk);
  endtask

  task automatic send_frame(input logic [DATA_BITS-1:0] data, input logic par_on,
                            input logic par_bit, input logic stop_bit);
    drive_bit(1'b0);
    for (int i = 0; i < DATA_BITS; i++) begin
      drive_bit(data[i]);
    end
    if (par_on) begin
      drive_bit(par_bit);
    end
    drive_bit(stop_bit);
    // Idle bit between frames
    drive_bit(1'b1);
  endtask

  // Send one character and update the model from the bits on the line
  task automatic send_char(input logic [DATA_BITS-1:0] data, input logic flip_par,
                           input logic stop_bit);
    logic     par_bit;
    rx_char_t exp;
    // Correct parity bit unless an inversion is requested
    par_bit = (^data) ^ cur_ctrl.parity_odd ^ flip_par;
    send_frame(data, cur_ctrl.parity_en, par_bit, stop_bit);
    if (cur_ctrl.rx_en) begin
      exp.data       = data;
      exp.parity_err = cur_ctrl.parity_en && ((^data) ^ par_bit ^ cur_ctrl.parity_odd);
      exp.frame_err  = !stop_bit;
      if (exp_q.size() < FIFO_DEPTH) begin
        exp_q.push_back(exp);
      end else begin
        exp_ovr = 1'b1;
      end
    end
  endtask

  // Poll STATUS until a character is there, then read and compare it
  task automatic drain_one();
    uart_status_t          st;
    logic [AXI_DATA_W-1:0] word;
    read_status(st);
    while (!st.not_empty) read_status(st);
    axi_read(ADDR_DATA, word);
    check_flag("DATA.valid", word[AXI_DATA_W-1], 1'b1);
    check_char("DATA.char", rx_char_t'(word[$bits(rx_char_t)-1:0]), exp_q.pop_front());
  endtask

  ////////////////////
  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

  ////////////////////
  // Test sequence
  initial begin
    logic [AXI_DATA_W-1:0] word;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // Parity off with each byte read back right away
    set_ctrl('{rx_en: 1'b1, parity_en: 1'b0, parity_odd: 1'b0});
    repeat (20) begin
      send_char(rand_byte(), 1'b0, 1'b1);
      drain_one();
    end

    // Even then odd parity with the parity bit randomly inverted
    for (int odd = 0; odd < 2; odd++) begin
      set_ctrl('{rx_en: 1'b1, parity_en: 1'b1, parity_odd: odd[0]});
      repeat (12) begin
        send_char(rand_byte(), rand_bit(), 1'b1);
        drain_one();
      end
    end

    // Stop bit forced low
    set_ctrl('{rx_en: 1'b1, parity_en: 1'b0, parity_odd: 1'b0});
    repeat (4) begin
      send_char(rand_byte(), 1'b0, 1'b0);
      drain_one();
    end

    // One frame more than the FIFO holds and no reads in between
    repeat (FIFO_DEPTH + 1) send_char(rand_byte(), 1'b0, 1'b1);
    expect_status();
    repeat (FIFO_DEPTH) drain_one();
    axi_read(ADDR_DATA, word);
    check_flag("DATA.valid", word[AXI_DATA_W-1], 1'b0);
    expect_status();
    axi_write(ADDR_STATUS, AXI_DATA_W'(3'b100));
    exp_ovr = 1'b0;
    expect_status();

    // Short low glitch is a false start
    @(posedge clk);
    rx <= 1'b0;
    repeat (HALF_BIT / 2) @(posedge clk);
    rx <= 1'b1;
    // A whole frame time, so a start taken by mistake would have pushed
    repeat (12 * CLKS_PER_BIT) @(posedge clk);
    expect_status();

    // Frame on the line is ignored while the receiver is off
    set_ctrl('{rx_en: 1'b0, parity_en: 1'b0, parity_odd: 1'b0});
    send_char(rand_byte(), 1'b0, 1'b1);
    expect_status();

    if (uart_rx_top_inst.props_inst.assert_fails != 0) begin
      $display("bound assertions failed %0d times", uart_rx_top_inst.props_inst.assert_fails);
      $display("Simulation FAILED");
      $fatal(1, "assertion failures");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
uart_pkg.sv
axil_if.sv
uart_baud_timer.sv
uart_rx_sampler.sv
uart_rx_fsm.sv
uart_rx_fifo.sv
uart_axil_regs.sv
uart_rx_top.sv
uart_rx_properties.sv
tb_uart_rx.sv

// ==== Bender.yml ====
package:
  name: uart_rx

sources:
  - uart_pkg.sv
  - axil_if.sv
  - uart_baud_timer.sv
  - uart_rx_sampler.sv
  - uart_rx_fsm.sv
  - uart_rx_fifo.sv
  - uart_axil_regs.sv
  - uart_rx_top.sv
  - target: simulation
    files:
      - uart_rx_properties.sv
      - tb_uart_rx.sv
